//--- dv/rv_core_sva.sv
// port-level checks only; internal stage handshakes of rv_core are not observed here
`timescale 1ns/1ps

module rv_core_sva (
	input logic                 clk,
	input logic                 rst,
	input logic                 in_valid,
	input logic [31:0]          in_inst,
	input logic                 in_ready,
	input logic                 retire_valid,
	input rv_pipe_pkg::retire_t retire
);
	//**************************************************
	// input stream
	//**************************************************
	// stalled word held until taken
	in_hold_a: assert property (@(posedge clk) disable iff (rst)
		in_valid && !in_ready |=> in_valid && $stable(in_inst))
		else $error("in_valid or in_inst changed while in_ready was low");

	//**************************************************
	// retire port
	//**************************************************
	// pipe empty right after reset
	reset_quiet_a: assert property (@(posedge clk) rst |=> !retire_valid)
		else $error("retire_valid high in the cycle after reset");

	illegal_no_wen_a: assert property (@(posedge clk) disable iff (rst)
		retire_valid && retire.illegal |-> !retire.wen)
		else $error("illegal instruction retired with wen set");
endmodule

bind rv_core rv_core_sva sva_i (.*);

//--- dv/rv_core_tb.sv
// random alu program; consecutive writes never share rd since a busy bit tracks one writer
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_core_tb;
	localparam int N_INST  = 300;
	localparam int TIMEOUT = N_INST * 8 + 100;

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 in_valid;
	logic [31:0]          in_inst;
	logic                 in_ready;
	logic                 retire_valid;
	rv_pipe_pkg::retire_t retire;

	integer               seed;
	int                   sent;
	int                   retired = 0;
	int                   cycles = 0;
	logic [31:0]          prog [N_INST];
	logic [`RV_XLEN-1:0]  model [`RV_NREGS];
	rv_pipe_pkg::retire_t exp_q [$];
	rv_pipe_pkg::retire_t exp_r;

	rv_core dut_i (
		.clk          (clk),
		.rst          (rst),
		.in_valid     (in_valid),
		.in_inst      (in_inst),
		.in_ready     (in_ready),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	// 40 ns period
	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic compare_field(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			abort_run("checked value differs from the expected value");
		end
	endtask

	//**************************************************
	// isa reference model
	//**************************************************
	function automatic rv_pipe_pkg::retire_t ref_exec(input logic [31:0] inst,
			input logic [`RV_XLEN-1:0] pc);
		rv_pipe_pkg::retire_t r;
		logic [`RV_XLEN-1:0]  a;
		logic [`RV_XLEN-1:0]  b;
		logic [`RV_XLEN-1:0]  imm_i;
		logic [`RV_XLEN-1:0]  v;
		logic                 ok;
		a     = model[inst[19:15]];
		b     = model[inst[24:20]];
		imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
		ok    = 1'b1;
		v     = '0;
		case (inst[6:0])
			rv_isa_pkg::op_reg: begin
				// funct7 and funct3 together pick the op
				case ({inst[31:25], inst[14:12]})
					{rv_isa_pkg::f7_base, rv_isa_pkg::f3_add_sub}: v = a + b;
					{rv_isa_pkg::f7_sub, rv_isa_pkg::f3_add_sub}:  v = a - b;
					{rv_isa_pkg::f7_base, rv_isa_pkg::f3_xor}:     v = a ^ b;
					{rv_isa_pkg::f7_base, rv_isa_pkg::f3_or}:      v = a | b;
					{rv_isa_pkg::f7_base, rv_isa_pkg::f3_and}:     v = a & b;
					default:                                       ok = 1'b0;
				endcase
			end
			rv_isa_pkg::op_imm: begin
				case (inst[14:12])
					rv_isa_pkg::f3_add_sub: v = a + imm_i;
					rv_isa_pkg::f3_xor:     v = a ^ imm_i;
					rv_isa_pkg::f3_or:      v = a | imm_i;
					rv_isa_pkg::f3_and:     v = a & imm_i;
					default:                ok = 1'b0;
				endcase
			end
			rv_isa_pkg::op_lui: v = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'h000};
			default:            ok = 1'b0;
		endcase
		if (!ok) begin
			v = '0;
		end
		// x0 keeps reading zero
		if (ok && inst[11:7] != 5'd0) begin
			model[inst[11:7]] = v;
		end
		r.pc      = pc;
		r.rd      = inst[11:7];
		r.value   = v;
		r.wen     = ok;
		r.illegal = !ok;
		return r;
	endfunction

	// program and expected records, in program order
	task automatic gen_program();
		int                  kind;
		logic [31:0]         r;
		logic [4:0]          rd;
		logic [4:0]          rs1;
		logic [4:0]          rs2;
		logic [4:0]          last_rd;
		logic [2:0]          f3;
		logic [`RV_XLEN-1:0] pc;
		for (int k = 0; k < `RV_NREGS; k++) begin
			model[k] = '0;
		end
		last_rd = 5'd0;
		pc      = `RV_RESET_PC;
		for (int i = 0; i < N_INST; i++) begin
			kind = $unsigned($random(seed)) % 12;
			r    = $random(seed);
			// x0..x3 only, so dependent chains are frequent
			rd   = {3'b000, r[1:0]};
			rs1  = {3'b000, r[3:2]};
			rs2  = {3'b000, r[5:4]};
			if (kind < 10 && rd != 5'd0 && rd == last_rd) begin
				rd = rd ^ 5'd1;
			end
			last_rd = (kind < 10) ? rd : 5'd0;
			case (kind)
				5:       f3 = rv_isa_pkg::f3_add_sub;
				6:       f3 = rv_isa_pkg::f3_xor;
				7:       f3 = rv_isa_pkg::f3_and;
				default: f3 = rv_isa_pkg::f3_or;
			endcase
			case (kind)
				0: prog[i] = {7'h00, rs2, rs1, rv_isa_pkg::f3_add_sub, rd, rv_isa_pkg::op_reg};
				1: prog[i] = {7'h20, rs2, rs1, rv_isa_pkg::f3_add_sub, rd, rv_isa_pkg::op_reg};
				2: prog[i] = {7'h00, rs2, rs1, rv_isa_pkg::f3_and, rd, rv_isa_pkg::op_reg};
				3: prog[i] = {7'h00, rs2, rs1, rv_isa_pkg::f3_or, rd, rv_isa_pkg::op_reg};
				4: prog[i] = {7'h00, rs2, rs1, rv_isa_pkg::f3_xor, rd, rv_isa_pkg::op_reg};
				5, 6, 7, 8: prog[i] = {r[31:20], rs1, f3, rd, rv_isa_pkg::op_imm};
				9: prog[i] = {r[31:12], rd, rv_isa_pkg::op_lui};
				// load opcode, not supported
				10: prog[i] = {r[31:7], 7'b0000011};
				// mul group funct7
				default: prog[i] = {7'b0000001, r[24:7], rv_isa_pkg::op_reg};
			endcase
			exp_q.push_back(ref_exec(prog[i], pc));
			pc = pc + 64'd4;
		end
	endtask

	//**************************************************
	// stimulus
	//**************************************************
	initial begin
		seed     = 32'hde299893;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_inst  = '0;
		sent     = 0;
		gen_program();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		// empty pipe after reset, input side open
		compare_field("retire_valid", 64'(retire_valid), 64'd0);
		compare_field("in_ready", 64'(in_ready), 64'd1);
		while (sent < N_INST) begin
			@(posedge clk);
			if (in_valid && in_ready) begin
				sent = sent + 1;
			end
			// a stalled word stays on the bus
			if (!in_valid || in_ready) begin
				if (sent < N_INST && ($random(seed) & 3) != 0) begin
					in_valid <= 1'b1;
					in_inst  <= prog[sent];
				end else begin
					in_valid <= 1'b0;
				end
			end
		end
		wait (retired == N_INST);
		// a few idle cycles catch extra retires
		repeat (4) @(posedge clk);
		$display("PASS: all tests");
		$finish;
	end

	// compare each retire against the oldest expected record
	always @(posedge clk) begin
		if (!rst && retire_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("retire strobe seen with no instruction outstanding");
			end else begin
				exp_r = exp_q.pop_front();
				compare_field("retire.pc", retire.pc, exp_r.pc);
				compare_field("retire.rd", 64'(retire.rd), 64'(exp_r.rd));
				compare_field("retire.value", retire.value, exp_r.value);
				compare_field("retire.wen", 64'(retire.wen), 64'(exp_r.wen));
				compare_field("retire.illegal", 64'(retire.illegal), 64'(exp_r.illegal));
				retired = retired + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT) begin
			abort_run("timeout: retirement stalled before all instructions retired");
		end
	end
endmodule

//--- run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/rv_core_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

//--- rv_core.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_stage_reg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_core.sv
dv/rv_core_sva.sv
dv/rv_core_tb.sv

//--- src/rv_core.sv
// in-order rv64i alu core; instruction stream in, retire strobe out with no back-pressure
`timescale 1ns/1ps

module rv_core (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 in_valid,
	input  logic [31:0]          in_inst,
	output logic                 in_ready,
	output logic                 retire_valid,
	output rv_pipe_pkg::retire_t retire
);
	// fetch to decode
	logic                 fe_valid;
	logic                 fe_ready;
	rv_pipe_pkg::fetch_t  fe_data;
	// decode to id_ex_reg
	logic                 id_valid;
	logic                 id_ready;
	rv_pipe_pkg::issue_t  id_data;
	// id_ex_reg to execute
	logic                 ix_valid;
	logic                 ix_ready;
	rv_pipe_pkg::issue_t  ix_data;
	rv_pipe_pkg::retire_t ex_data;

	//**************************************************
	// front end
	//**************************************************
	rv_fetch fetch_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_inst   (in_inst),
		.in_ready  (in_ready),
		.out_valid (fe_valid),
		.out_ready (fe_ready),
		.out_data  (fe_data)
	);

	// retire record doubles as writeback and scoreboard clear
	rv_decode decode_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (fe_valid),
		.in_ready  (fe_ready),
		.in_data   (fe_data),
		.out_valid (id_valid),
		.out_ready (id_ready),
		.out_data  (id_data),
		.wb_valid  (retire_valid),
		.wb        (retire)
	);

	//**************************************************
	// execute and retire
	//**************************************************
	rv_stage_reg #(.payload_t(rv_pipe_pkg::issue_t)) id_ex_reg (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (id_valid),
		.in_ready  (id_ready),
		.in_data   (id_data),
		.out_valid (ix_valid),
		.out_ready (ix_ready),
		.out_data  (ix_data)
	);

	rv_execute execute_i (
		.in_data  (ix_data),
		.out_data (ex_data)
	);

	// retire port always accepts
	rv_stage_reg #(.payload_t(rv_pipe_pkg::retire_t)) ex_rt_reg (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (ix_valid),
		.in_ready  (ix_ready),
		.in_data   (ex_data),
		.out_valid (retire_valid),
		.out_ready (1'b1),
		.out_data  (retire)
	);
endmodule

//--- src/rv_core_settings.svh
// core parameters; the packed types assume a 64-bit xlen and 32 registers (5-bit indices)
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// register width in bits
`define RV_XLEN 64

// general registers, x0 included
`define RV_NREGS 32

// pc of the first accepted instruction
// must stay word aligned
`define RV_RESET_PC 64'h0000_0000_8000_0000

`endif

//--- src/rv_decode.sv
// no bypass: a source stays busy until the cycle after its writer retires
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_decode (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  rv_pipe_pkg::fetch_t  in_data,
	output logic                 out_valid,
	input  logic                 out_ready,
	output rv_pipe_pkg::issue_t  out_data,
	input  logic                 wb_valid,
	input  rv_pipe_pkg::retire_t wb
);
	logic [31:0]           inst;
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	rv_pipe_pkg::reg_idx_t rd;
	rv_pipe_pkg::reg_idx_t rs1;
	rv_pipe_pkg::reg_idx_t rs2;
	logic [`RV_XLEN-1:0]   imm_i;
	logic [`RV_XLEN-1:0]   imm_u;
	logic [`RV_XLEN-1:0]   rs1_val;
	logic [`RV_XLEN-1:0]   rs2_val;
	logic [`RV_XLEN-1:0]   op_b;
	logic [`RV_XLEN-1:0]   regs [`RV_NREGS];
	logic [`RV_NREGS-1:0]  busy_q;
	rv_isa_pkg::alu_op_e   alu_op;
	logic                  legal;
	logic                  use_rs1;
	logic                  use_rs2;
	logic                  hazard;
	logic                  issue;
	logic                  wb_write;

	//**************************************************
	// field extraction
	//**************************************************
	assign inst   = in_data.inst;
	assign opcode = inst[rv_isa_pkg::op_hi:rv_isa_pkg::op_lo];
	assign rd     = inst[rv_isa_pkg::rd_hi:rv_isa_pkg::rd_lo];
	assign funct3 = inst[rv_isa_pkg::f3_hi:rv_isa_pkg::f3_lo];
	assign rs1    = inst[rv_isa_pkg::rs1_hi:rv_isa_pkg::rs1_lo];
	assign rs2    = inst[rv_isa_pkg::rs2_hi:rv_isa_pkg::rs2_lo];
	assign funct7 = inst[rv_isa_pkg::f7_hi:rv_isa_pkg::f7_lo];
	// sign bit is always inst[31]
	assign imm_i  = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_u  = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};

	// opcode and funct map to an alu op
	always_comb begin
		legal   = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		alu_op  = rv_isa_pkg::add;
		op_b    = rs2_val;
		case (opcode)
			rv_isa_pkg::op_reg: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				if (funct7 == rv_isa_pkg::f7_base) begin
					legal = 1'b1;
					case (funct3)
						rv_isa_pkg::f3_add_sub: alu_op = rv_isa_pkg::add;
						rv_isa_pkg::f3_xor:     alu_op = rv_isa_pkg::xor_op;
						rv_isa_pkg::f3_or:      alu_op = rv_isa_pkg::or_op;
						rv_isa_pkg::f3_and:     alu_op = rv_isa_pkg::and_op;
						default:                legal  = 1'b0;
					endcase
				end else if (funct7 == rv_isa_pkg::f7_sub &&
						funct3 == rv_isa_pkg::f3_add_sub) begin
					legal  = 1'b1;
					alu_op = rv_isa_pkg::sub;
				end
			end
			rv_isa_pkg::op_imm: begin
				// funct7 bits are immediate here
				use_rs1 = 1'b1;
				op_b    = imm_i;
				legal   = 1'b1;
				case (funct3)
					rv_isa_pkg::f3_add_sub: alu_op = rv_isa_pkg::add;
					rv_isa_pkg::f3_xor:     alu_op = rv_isa_pkg::xor_op;
					rv_isa_pkg::f3_or:      alu_op = rv_isa_pkg::or_op;
					rv_isa_pkg::f3_and:     alu_op = rv_isa_pkg::and_op;
					default:                legal  = 1'b0;
				endcase
			end
			rv_isa_pkg::op_lui: begin
				legal  = 1'b1;
				alu_op = rv_isa_pkg::pass_b;
				op_b   = imm_u;
			end
			default: legal = 1'b0;
		endcase
	end

	//**************************************************
	// register file and scoreboard
	//**************************************************
	// x0 reads zero, never written
	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

	// illegal words never stall
	assign hazard   = legal && ((use_rs1 && busy_q[rs1]) || (use_rs2 && busy_q[rs2]));
	assign in_ready = out_ready && !hazard;
	assign issue    = in_valid && in_ready;
	assign wb_write = wb_valid && wb.wen && wb.rd != '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= '0;
			// registers start at zero
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb_write) begin
				regs[wb.rd]   <= wb.value;
				busy_q[wb.rd] <= 1'b0;
			end
			// later assignment, so set beats clear
			if (issue && legal && rd != '0) begin
				busy_q[rd] <= 1'b1;
			end
		end
	end

	// issue payload
	assign out_valid        = in_valid && !hazard;
	assign out_data.pc      = in_data.pc;
	assign out_data.rd      = rd;
	assign out_data.alu_op  = alu_op;
	assign out_data.a       = use_rs1 ? rs1_val : '0;
	assign out_data.b       = legal ? op_b : '0;
	assign out_data.wen     = legal;
	assign out_data.illegal = !legal;
endmodule

//--- src/rv_execute.sv
// purely combinational alu; 64-bit wraparound, no overflow flag, illegal gives zero
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_execute (
	input  rv_pipe_pkg::issue_t  in_data,
	output rv_pipe_pkg::retire_t out_data
);
	logic [`RV_XLEN-1:0] result;

	//**************************************************
	// alu
	//**************************************************
	always_comb begin
		case (in_data.alu_op)
			rv_isa_pkg::add: begin
				// carry out dropped
				result = in_data.a + in_data.b;
			end
			rv_isa_pkg::sub: begin
				result = in_data.a - in_data.b;
			end
			rv_isa_pkg::and_op: begin
				result = in_data.a & in_data.b;
			end
			rv_isa_pkg::or_op: begin
				result = in_data.a | in_data.b;
			end
			rv_isa_pkg::xor_op: begin
				result = in_data.a ^ in_data.b;
			end
			rv_isa_pkg::pass_b: begin
				// lui, immediate already shifted
				result = in_data.b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// retire record
	// control bits pass straight through
	assign out_data.pc      = in_data.pc;
	assign out_data.rd      = in_data.rd;
	assign out_data.wen     = in_data.wen;
	assign out_data.illegal = in_data.illegal;
	// illegal words show a zero value
	assign out_data.value   = in_data.illegal ? '0 : result;
endmodule

//--- src/rv_fetch.sv
// no instruction memory; each accepted word gets the next sequential pc, no branches
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_fetch (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  logic [31:0]         in_inst,
	output logic                in_ready,
	output logic                out_valid,
	input  logic                out_ready,
	output rv_pipe_pkg::fetch_t out_data
);
	logic [`RV_XLEN-1:0] pc_q;
	logic                valid_q;
	rv_pipe_pkg::fetch_t data_q;

	// same acceptance rule as the stage register
	assign in_ready = !valid_q || out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q    <= `RV_RESET_PC;
			valid_q <= 1'b0;
		end else if (in_valid && in_ready) begin
			// pc advances only on a real transfer
			pc_q    <= pc_q + 'd4;
			valid_q <= 1'b1;
		end else if (out_ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q.pc   <= pc_q;
			data_q.inst <= in_inst;
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;
endmodule

//--- src/rv_isa_pkg.sv
// rv64i encodings for the supported integer subset only; no compressed or system opcodes
package rv_isa_pkg;

	//**************************************************
	// instruction field positions
	//**************************************************
	localparam int op_hi  = 6;
	localparam int op_lo  = 0;
	localparam int rd_hi  = 11;
	localparam int rd_lo  = 7;
	localparam int f3_hi  = 14;
	localparam int f3_lo  = 12;
	localparam int rs1_hi = 19;
	localparam int rs1_lo = 15;
	localparam int rs2_hi = 24;
	localparam int rs2_lo = 20;
	localparam int f7_hi  = 31;
	localparam int f7_lo  = 25;

	//**************************************************
	// opcodes and function codes
	//**************************************************
	// register-register alu group
	localparam logic [6:0] op_reg = 7'b0110011;
	// register-immediate alu group
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct7 only tells add from sub here
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_sub  = 7'b0100000;

	// alu operation, pass_b carries the lui immediate
	typedef enum logic [3:0] {
		add,
		sub,
		and_op,
		or_op,
		xor_op,
		pass_b
	} alu_op_e;

endpackage

//--- src/rv_pipe_pkg.sv
// stage payloads; fetch_t is 96 bits only while RV_XLEN is 64
`include "rv_core_settings.svh"

package rv_pipe_pkg;

	// register index and data word
	typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;
	typedef logic [`RV_XLEN-1:0] xword_t;

	//**************************************************
	// fetch to decode
	//**************************************************
	typedef struct packed {
		xword_t      pc;
		logic [31:0] inst;
	} fetch_t;

	//**************************************************
	// decode to execute, operands already selected
	//**************************************************
	typedef struct packed {
		xword_t              pc;
		reg_idx_t            rd;
		rv_isa_pkg::alu_op_e alu_op;
		xword_t              a;
		xword_t              b;
		logic                wen;
		logic                illegal;
	} issue_t;

	// execute to retire, also the retire port record
	typedef struct packed {
		xword_t   pc;
		reg_idx_t rd;
		xword_t   value;
		logic     wen;
		logic     illegal;
	} retire_t;

endpackage

//--- src/rv_stage_reg.sv
// single-entry valid/ready register; full throughput, but ready is combinational from out_ready
`timescale 1ns/1ps

module rv_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);
	logic     valid_q;
	payload_t data_q;

	// free when empty or draining this cycle
	assign in_ready = !valid_q || out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (in_valid && in_ready) begin
			valid_q <= 1'b1;
		end else if (out_ready) begin
			// held entry left, nothing new
			valid_q <= 1'b0;
		end
	end

	// payload only moves on a transfer
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;
endmodule
